//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // base integer width, rv64
    localparam int xlen = 64;

    // x0..x31
    localparam int reg_addr_w = 5;

    // boot address, also the reset value of the pc in the pipe
    localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

    // what the execute side hands over
    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,  // result goes straight to rd
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_class_e;

    // funct3 of the load/store opcodes
    // bit 2 set means zero extension on loads
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_D  = 3'b011,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101,
        SZ_WU = 3'b110
    } mem_size_e;

endpackage

//--- src/lsu_pkg.sv
package lsu_pkg;

    // byte lanes in one data word
    localparam int lanes = 8;

    // one write strobe per byte lane
    typedef logic [lanes-1:0] byte_mask_t;

    // one RAM word, seen at every access granularity
    // lane 0 is the least significant byte (little endian)
    typedef union packed {
        logic [lanes-1:0][7:0]   b;   // bytes
        logic [lanes/2-1:0][15:0] h;  // halves
        logic [lanes/4-1:0][31:0] w;  // words
        logic [rv_isa_pkg::xlen-1:0] dw;  // whole doubleword
    } mem_word_u;

endpackage

//--- src/mem_access_stage.sv
`timescale 1ns/1ps

module mem_access_stage
    import rv_isa_pkg::*;
    import lsu_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid_i,
    input  op_class_e                      in_class_i,
    input  mem_size_e                      in_size_i,
    input  logic [xlen-1:0]                in_alu_res_i,
    input  logic [xlen-1:0]                in_store_data_i,
    input  logic                           slot_ready_i,
    output logic                           in_ready_o,
    output logic                           fire_o,
    output logic                           ram_en_o,
    output byte_mask_t                     ram_we_o,
    output logic [$clog2(DEPTH_WORDS)-1:0] ram_index_o,
    output mem_word_u                      ram_wdata_o
);

    localparam int idx_w = $clog2(DEPTH_WORDS);

    logic       is_mem;
    logic       is_store;
    logic [2:0] byte_off;
    byte_mask_t lane_mask;
    mem_word_u  store_word;
    logic       aligned;

    // ready comes straight from the slot, accept when both high
    assign in_ready_o = slot_ready_i;
    assign fire_o     = in_valid_i && slot_ready_i;

    assign is_mem   = (in_class_i == OP_LOAD) || (in_class_i == OP_STORE);
    assign is_store = (in_class_i == OP_STORE);

    // alu result doubles as the effective address
    assign byte_off    = in_alu_res_i[2:0];
    assign ram_index_o = in_alu_res_i[3 +: idx_w];

    // place store data in its lanes
    always_comb begin
        lane_mask  = '0;
        store_word = '0;
        case (in_size_i)
            SZ_B, SZ_BU: begin
                lane_mask = 8'h01 << byte_off;
                store_word.b[byte_off] = in_store_data_i[7:0];
            end
            SZ_H, SZ_HU: begin
                lane_mask = 8'h03 << byte_off;
                store_word.h[byte_off[2:1]] = in_store_data_i[15:0];
            end
            SZ_W, SZ_WU: begin
                lane_mask = 8'h0f << byte_off;
                store_word.w[byte_off[2]] = in_store_data_i[31:0];
            end
            default: begin  // doubleword
                lane_mask     = 8'hff;
                store_word.dw = in_store_data_i;
            end
        endcase
    end

    // ram strobes, only on an accepted memory op
    assign ram_en_o    = fire_o && is_mem;
    assign ram_we_o    = (fire_o && is_store) ? lane_mask : '0;
    assign ram_wdata_o = store_word;

    // natural alignment per size
    always_comb begin
        case (in_size_i)
            SZ_B, SZ_BU: aligned = 1'b1;
            SZ_H, SZ_HU: aligned = (byte_off[0] == 1'b0);
            SZ_W, SZ_WU: aligned = (byte_off[1:0] == 2'b00);
            default:     aligned = (byte_off == 3'b000);
        endcase
    end

    // misaligned accesses are not handled anywhere downstream
    a_aligned_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fire_o && is_mem) |-> aligned
    ) else $error("misaligned access at %h", in_alu_res_i);

    // producer must hold the op while it waits
    a_in_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_valid_i && !in_ready_o) |=>
            in_valid_i && $stable(in_class_i) && $stable(in_size_i)
            && $stable(in_alu_res_i) && $stable(in_store_data_i)
    ) else $error("input op changed while stalled");

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import lsu_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           en_i,
    input  byte_mask_t                     we_i,
    input  logic [$clog2(DEPTH_WORDS)-1:0] index_i,
    input  mem_word_u                      wdata_i,
    output mem_word_u                      rdata_o
);

    mem_word_u mem [DEPTH_WORDS];

    logic rd_en;

    // a read is an enabled cycle with no lane written
    assign rd_en = en_i && (we_i == '0);

    // byte lane writes
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int i = 0; i < lanes; i++) begin
                if (we_i[i]) begin
                    mem[index_i].b[i] <= wdata_i.b[i];
                end
            end
        end
    end

    // registered read port, keeps its value otherwise
    // so a stalled load still sees its data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_o <= mem[index_i];
        end
    end

endmodule

//--- src/mem_wb_regs.sv
`timescale 1ns/1ps

module mem_wb_regs
    import rv_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fire_i,
    input  op_class_e             class_i,
    input  mem_size_e             size_i,
    input  logic [xlen-1:0]       alu_res_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic [xlen-1:0]       pc_i,
    input  logic                  wb_ready_i,
    output logic                  slot_ready_o,
    output logic                  valid_o,
    output op_class_e             class_o,
    output mem_size_e             size_o,
    output logic [xlen-1:0]       alu_res_o,
    output logic [reg_addr_w-1:0] rd_o,
    output logic [xlen-1:0]       pc_o
);

    // free slot or the current beat leaves this cycle
    assign slot_ready_o = !valid_o || wb_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o   <= 1'b0;
            class_o   <= OP_ALU;
            size_o    <= SZ_B;
            alu_res_o <= '0;
            rd_o      <= '0;
            pc_o      <= pc_reset;
        end else if (fire_i) begin
            valid_o   <= 1'b1;  // refill may overlap a drain
            class_o   <= class_i;
            size_o    <= size_i;
            alu_res_o <= alu_res_i;
            rd_o      <= rd_i;
            pc_o      <= pc_i;
        end else if (wb_ready_i) begin
            valid_o <= 1'b0;  // drained with nothing behind it
        end
        // on a stall everything keeps its value
    end

    // the input side must never overwrite a waiting op
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!rst_n)
        fire_i |-> (!valid_o || wb_ready_i)
    ) else $error("fire into a full slot");

endmodule

//--- src/load_align_wb.sv
`timescale 1ns/1ps

module load_align_wb
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic                  valid_i,
    input  op_class_e             class_i,
    input  mem_size_e             size_i,
    input  logic [xlen-1:0]       alu_res_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic [xlen-1:0]       pc_i,
    input  mem_word_u             rdata_i,
    output logic                  wb_valid_o,
    output logic [xlen-1:0]       wb_pc_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output logic                  wb_wen_o,
    output logic [xlen-1:0]       wb_data_o
);

    logic [2:0]      byte_off;
    logic            sign_ext;
    logic [7:0]      pick_b;
    logic [15:0]     pick_h;
    logic [31:0]     pick_w;
    logic [xlen-1:0] load_val;

    assign byte_off = alu_res_i[2:0];
    assign sign_ext = !size_i[2];  // lb/lh/lw sign extend, *u zero extend

    // lane select through the union views
    assign pick_b = rdata_i.b[byte_off];
    assign pick_h = rdata_i.h[byte_off[2:1]];
    assign pick_w = rdata_i.w[byte_off[2]];

    always_comb begin
        case (size_i)
            SZ_B, SZ_BU: load_val = {{(xlen-8){sign_ext & pick_b[7]}}, pick_b};
            SZ_H, SZ_HU: load_val = {{(xlen-16){sign_ext & pick_h[15]}}, pick_h};
            SZ_W, SZ_WU: load_val = {{(xlen-32){sign_ext & pick_w[31]}}, pick_w};
            default:     load_val = rdata_i.dw;  // ld
        endcase
    end

    // alu ops and stores carry the alu result, stores just don't write it
    assign wb_data_o = (class_i == OP_LOAD) ? load_val : alu_res_i;

    // no write for stores or x0
    assign wb_wen_o = (class_i != OP_STORE) && (rd_i != '0);

    assign wb_valid_o = valid_i;
    assign wb_pc_o    = pc_i;
    assign wb_rd_o    = rd_i;

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
    import rv_isa_pkg::*;
    import lsu_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid_i,
    input  op_class_e             in_class_i,
    input  mem_size_e             in_size_i,
    input  logic [xlen-1:0]       in_alu_res_i,
    input  logic [xlen-1:0]       in_store_data_i,
    input  logic [reg_addr_w-1:0] in_rd_i,
    input  logic [xlen-1:0]       in_pc_i,
    input  logic                  wb_ready_i,
    output logic                  in_ready_o,
    output logic                  wb_valid_o,
    output logic [xlen-1:0]       wb_pc_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output logic                  wb_wen_o,
    output logic [xlen-1:0]       wb_data_o
);

    localparam int idx_w = $clog2(DEPTH_WORDS);

    logic             slot_ready;
    logic             fire;
    logic             ram_en;
    byte_mask_t       ram_we;
    logic [idx_w-1:0] ram_index;
    mem_word_u        ram_wdata;
    mem_word_u        ram_rdata;

    // MEM/WB slot contents
    logic                  mw_valid;
    op_class_e             mw_class;
    mem_size_e             mw_size;
    logic [xlen-1:0]       mw_alu_res;
    logic [reg_addr_w-1:0] mw_rd;
    logic [xlen-1:0]       mw_pc;

    mem_access_stage #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_mem_access_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .in_class_i      (in_class_i),
        .in_size_i       (in_size_i),
        .in_alu_res_i    (in_alu_res_i),
        .in_store_data_i (in_store_data_i),
        .slot_ready_i    (slot_ready),
        .in_ready_o      (in_ready_o),
        .fire_o          (fire),
        .ram_en_o        (ram_en),
        .ram_we_o        (ram_we),
        .ram_index_o     (ram_index),
        .ram_wdata_o     (ram_wdata)
    );

    data_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .index_i (ram_index),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    mem_wb_regs u_mem_wb_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .fire_i       (fire),
        .class_i      (in_class_i),
        .size_i       (in_size_i),
        .alu_res_i    (in_alu_res_i),
        .rd_i         (in_rd_i),
        .pc_i         (in_pc_i),
        .wb_ready_i   (wb_ready_i),
        .slot_ready_o (slot_ready),
        .valid_o      (mw_valid),
        .class_o      (mw_class),
        .size_o       (mw_size),
        .alu_res_o    (mw_alu_res),
        .rd_o         (mw_rd),
        .pc_o         (mw_pc)
    );

    load_align_wb u_load_align_wb (
        .valid_i    (mw_valid),
        .class_i    (mw_class),
        .size_i     (mw_size),
        .alu_res_i  (mw_alu_res),
        .rd_i       (mw_rd),
        .pc_i       (mw_pc),
        .rdata_i    (ram_rdata),
        .wb_valid_o (wb_valid_o),
        .wb_pc_o    (wb_pc_o),
        .wb_rd_o    (wb_rd_o),
        .wb_wen_o   (wb_wen_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

//--- tests/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

// shadow copy of the data RAM keyed by word index
logic [xlen-1:0] shadow_mem [int];

function automatic int size_bytes(input mem_size_e sz);
    case (sz)
        SZ_B, SZ_BU: return 1;
        SZ_H, SZ_HU: return 2;
        SZ_W, SZ_WU: return 4;
        default:     return 8;
    endcase
endfunction

// store data bytes move up to the offset inside the word
function automatic logic [xlen-1:0] store_merge(input logic [xlen-1:0] old_word,
        input logic [xlen-1:0] data, input mem_size_e sz, input int off);
    logic [xlen-1:0] merged;
    int              n;
    merged = old_word;
    n      = size_bytes(sz);
    for (int i = 0; i < n; i++) begin
        merged[8*(off+i) +: 8] = data[8*i +: 8];
    end
    return merged;
endfunction

function automatic logic [xlen-1:0] load_result(input logic [xlen-1:0] word,
        input mem_size_e sz, input int off);
    logic [xlen-1:0] field;
    logic [xlen-1:0] keep;
    int              nbits;
    nbits = 8 * size_bytes(sz);
    field = word >> (8 * off);
    if (nbits == xlen) begin
        return field;
    end
    keep  = (64'd1 << nbits) - 64'd1;
    field = field & keep;
    if (!sz[2] && field[nbits-1]) begin
        field = field | ~keep;  // signed codes copy the top bit up
    end
    return field;
endfunction

function automatic void shadow_store(input int idx, input mem_size_e sz, input int off,
        input logic [xlen-1:0] data);
    logic [xlen-1:0] old_word;
    old_word = shadow_mem.exists(idx) ? shadow_mem[idx] : '0;
    shadow_mem[idx] = store_merge(old_word, data, sz, off);
endfunction

function automatic logic [xlen-1:0] shadow_load(input int idx, input mem_size_e sz,
        input int off);
    return load_result(shadow_mem.exists(idx) ? shadow_mem[idx] : '0, sz, off);
endfunction

// alu results and loads reach the register file unless rd is x0
function automatic logic expect_wen(input op_class_e cls, input logic [reg_addr_w-1:0] rd);
    return ((cls == OP_ALU) || (cls == OP_LOAD)) && (rd != '0);
endfunction

`endif

//--- tests/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top
    import rv_isa_pkg::*;
();

    localparam int depth_words = 256;
    localparam int rst_cycles  = 16;
    localparam int lane_loads  = 29;  // each load size at each aligned offset
    localparam int n_alu       = 8;
    localparam int n_pairs     = 4;
    localparam int n_rand      = 60;
    localparam int n_ops       = n_alu + 4 * (2 + lane_loads) + (1 + lane_loads)
                                 + 2 * n_pairs + n_rand;
    localparam int cycle_limit = 4 * n_ops + rst_cycles;
    localparam logic [xlen-1:0] base_addr = 64'h400;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic                  chk_data;
        logic [xlen-1:0]       data;
    } beat_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid_i;
    op_class_e             in_class_i;
    mem_size_e             in_size_i;
    logic [xlen-1:0]       in_alu_res_i;
    logic [xlen-1:0]       in_store_data_i;
    logic [reg_addr_w-1:0] in_rd_i;
    logic [xlen-1:0]       in_pc_i;
    logic                  wb_ready_i;
    logic                  in_ready_o;
    logic                  wb_valid_o;
    logic [xlen-1:0]       wb_pc_o;
    logic [reg_addr_w-1:0] wb_rd_o;
    logic                  wb_wen_o;
    logic [xlen-1:0]       wb_data_o;

    beat_t                 exp_q[$];
    beat_t                 want_in;
    beat_t                 want_out;
    logic                  held_last = 1'b0;
    logic [xlen-1:0]       held_pc;
    logic [reg_addr_w-1:0] held_rd;
    logic                  held_wen;
    logic [xlen-1:0]       held_data;
    logic                  bp_on;
    logic [31:0]           bp_rand;
    integer                seed = 32'hfaae_6b06;
    integer                bp_seed = 32'hfaae_6b06 ^ 32'h0000_ffff;  // own stream for wb_ready
    logic [xlen-1:0]       pc_ctr = 64'h8000_1000;
    int                    ops_sent = 0;
    int                    beats_seen = 0;
    int                    cycle_cnt = 0;

    `include "lsu_ref_model.svh"

    lsu_top #(
        .DEPTH_WORDS (depth_words)
    ) u_lsu_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .in_class_i      (in_class_i),
        .in_size_i       (in_size_i),
        .in_alu_res_i    (in_alu_res_i),
        .in_store_data_i (in_store_data_i),
        .in_rd_i         (in_rd_i),
        .in_pc_i         (in_pc_i),
        .wb_ready_i      (wb_ready_i),
        .in_ready_o      (in_ready_o),
        .wb_valid_o      (wb_valid_o),
        .wb_pc_o         (wb_pc_o),
        .wb_rd_o         (wb_rd_o),
        .wb_wen_o        (wb_wen_o),
        .wb_data_o       (wb_data_o)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
            input logic [xlen-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, want));
        end
    endtask

    task automatic check_rd(input string name, input logic [reg_addr_w-1:0] got,
            input logic [reg_addr_w-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, want));
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic logic [xlen-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic logic [reg_addr_w-1:0] random_rd();
        logic [31:0] r;
        r = $random(seed);
        return r[reg_addr_w-1:0];
    endfunction

    function automatic mem_size_e size_by_number(input int k);
        case (k)
            0:       return SZ_B;
            1:       return SZ_BU;
            2:       return SZ_H;
            3:       return SZ_HU;
            4:       return SZ_W;
            5:       return SZ_WU;
            default: return SZ_D;
        endcase
    endfunction

    function automatic logic [xlen-1:0] word_addr(input int w);
        return base_addr + 64'(w * 8);
    endfunction

    function automatic int word_index(input logic [xlen-1:0] addr);
        return int'((addr >> 3) % 64'(depth_words));
    endfunction

    // holds the op until the edge that takes it
    task automatic send_op(input op_class_e cls, input mem_size_e sz,
            input logic [xlen-1:0] alu, input logic [xlen-1:0] sdata,
            input logic [reg_addr_w-1:0] rd);
        in_valid_i      <= 1'b1;
        in_class_i      <= cls;
        in_size_i       <= sz;
        in_alu_res_i    <= alu;
        in_store_data_i <= sdata;
        in_rd_i         <= rd;
        in_pc_i         <= pc_ctr;
        pc_ctr = pc_ctr + 64'd4;
        @(posedge clk);
        while (!in_ready_o) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycle();
        in_valid_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic load_all_lanes(input logic [xlen-1:0] addr);
        mem_size_e sz;
        for (int k = 0; k < 7; k++) begin
            sz = size_by_number(k);
            for (int off = 0; off < 8; off += size_bytes(sz)) begin
                send_op(OP_LOAD, sz, addr + 64'(off), '0, random_rd());
            end
        end
    endtask

    task automatic alu_pass_through();
        logic [reg_addr_w-1:0] rd;
        for (int i = 0; i < n_alu; i++) begin
            rd = random_rd();
            if (i == 0) begin
                rd = '0;  // x0 never written
            end
            send_op(OP_ALU, SZ_D, rand64(), '0, rd);
        end
    endtask

    task automatic lane_sweep();
        mem_size_e sz;
        int        off;
        for (int w = 0; w < 4; w++) begin
            send_op(OP_STORE, SZ_D, word_addr(w), rand64(), random_rd());
            sz  = size_by_number(6 - 2 * w);  // d, w, h, b
            off = rand_below(8) & ~(size_bytes(sz) - 1);
            send_op(OP_STORE, sz, word_addr(w) + 64'(off), rand64(), random_rd());
            load_all_lanes(word_addr(w));
        end
    endtask

    task automatic sign_ext_loads();
        // top bit set in every byte, half and word
        send_op(OP_STORE, SZ_D, word_addr(4), 64'hf0e1_d2c3_b4a5_9687, random_rd());
        load_all_lanes(word_addr(4));
    endtask

    task automatic store_load_pairs();
        mem_size_e       sz;
        logic [xlen-1:0] addr;
        for (int j = 0; j < n_pairs; j++) begin
            sz   = size_by_number(2 * j);
            addr = word_addr(4) + 64'(rand_below(8) & ~(size_bytes(sz) - 1));
            send_op(OP_STORE, sz, addr, rand64(), random_rd());
            send_op(OP_LOAD, sz, addr, '0, random_rd());  // very next cycle
        end
    endtask

    task automatic random_traffic();
        int              kind;
        int              off;
        mem_size_e       sz;
        logic [xlen-1:0] addr;
        bp_on <= 1'b1;
        for (int i = 0; i < n_rand; i++) begin
            if (rand_below(4) == 0) begin
                idle_cycle();
            end
            kind = rand_below(3);
            sz   = (kind == 2) ? size_by_number(2 * rand_below(4)) : size_by_number(rand_below(7));
            off  = rand_below(8) & ~(size_bytes(sz) - 1);
            addr = word_addr(rand_below(5)) + 64'(off);  // only words written earlier
            case (kind)
                0:       send_op(OP_ALU, SZ_D, rand64(), '0, random_rd());
                1:       send_op(OP_LOAD, sz, addr, '0, random_rd());
                default: send_op(OP_STORE, sz, addr, rand64(), random_rd());
            endcase
        end
        bp_on <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (bp_on) begin
            bp_rand = $random(bp_seed);
            wb_ready_i <= bp_rand[0];
        end else begin
            wb_ready_i <= 1'b1;
        end
    end

    // scoreboard entry per accepted op in program order
    always @(posedge clk) begin
        if (rst_n && in_valid_i && in_ready_o) begin
            want_in.pc       = in_pc_i;
            want_in.rd       = in_rd_i;
            want_in.wen      = expect_wen(in_class_i, in_rd_i);
            want_in.chk_data = (in_class_i != OP_STORE);  // store beats carry no result
            want_in.data     = in_alu_res_i;
            if (in_class_i == OP_LOAD) begin
                want_in.data = shadow_load(word_index(in_alu_res_i), in_size_i,
                                           int'(in_alu_res_i[2:0]));
            end else if (in_class_i == OP_STORE) begin
                shadow_store(word_index(in_alu_res_i), in_size_i, int'(in_alu_res_i[2:0]),
                             in_store_data_i);
            end
            exp_q.push_back(want_in);
            ops_sent++;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (held_last) begin  // beat was waiting last cycle
                check_flag("wb_valid_o held", wb_valid_o, 1'b1);
                check_word("wb_pc_o held", wb_pc_o, held_pc);
                check_rd("wb_rd_o held", wb_rd_o, held_rd);
                check_flag("wb_wen_o held", wb_wen_o, held_wen);
                check_word("wb_data_o held", wb_data_o, held_data);
            end
            if (wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail_run("writeback beat arrived with no op outstanding");
                end else begin
                    want_out = exp_q.pop_front();
                    check_word("wb_pc_o", wb_pc_o, want_out.pc);
                    check_rd("wb_rd_o", wb_rd_o, want_out.rd);
                    check_flag("wb_wen_o", wb_wen_o, want_out.wen);
                    if (want_out.chk_data) begin
                        check_word("wb_data_o", wb_data_o, want_out.data);
                    end
                    beats_seen++;
                end
            end
            held_last = wb_valid_o && !wb_ready_i;
            held_pc   = wb_pc_o;
            held_rd   = wb_rd_o;
            held_wen  = wb_wen_o;
            held_data = wb_data_o;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("timeout: pipeline stalled, %0d of %0d beats after %0d cycles",
                               beats_seen, n_ops, cycle_cnt));
        end
    end

    initial begin
        rst_n           <= 1'b0;
        in_valid_i      <= 1'b0;
        in_class_i      <= OP_ALU;
        in_size_i       <= SZ_D;
        in_alu_res_i    <= '0;
        in_store_data_i <= '0;
        in_rd_i         <= '0;
        in_pc_i         <= '0;
        wb_ready_i      <= 1'b1;
        bp_on           <= 1'b0;
        repeat (rst_cycles) begin
            @(posedge clk);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
            check_flag("in_ready_o", in_ready_o, 1'b1);
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("wb_valid_o", wb_valid_o, 1'b0);  // first cycle out of reset
        check_flag("in_ready_o", in_ready_o, 1'b1);

        alu_pass_through();
        lane_sweep();
        sign_ext_loads();
        store_load_pairs();
        random_traffic();
        in_valid_i <= 1'b0;

        while (beats_seen < n_ops) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (ops_sent != n_ops || beats_seen != n_ops || exp_q.size() != 0) begin
            fail_run($sformatf("run ended with %0d ops accepted, %0d beats, %0d still queued",
                               ops_sent, beats_seen, exp_q.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+tests
src/rv_isa_pkg.sv
src/lsu_pkg.sv
src/mem_access_stage.sv
src/data_ram.sv
src/mem_wb_regs.sv
src/load_align_wb.sv
src/lsu_top.sv
tests/tb_lsu_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_lsu_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
